//--- logic/apb_decoder.sv
// APB address decoder for the soc top.
// Selects one target per transfer from the region and io block fields,
// forwards the request to it and returns its response. Unused io blocks
// get an error answer generated here in the first access cycle.
`timescale 1ns/100ps

module apb_decoder
  import bus_defs_pkg::*;
(
  input  logic     clk_50,
  input  logic     reset,
  input  apb_req_t req,
  output apb_rsp_t rsp,
  output apb_req_t sram_req,
  output apb_req_t flash_req,
  output apb_req_t crtc_req,
  output apb_req_t gpio_req,
  input  apb_rsp_t sram_rsp,
  input  apb_rsp_t flash_rsp,
  input  apb_rsp_t crtc_rsp,
  input  apb_rsp_t gpio_rsp
);

  apb_addr_u addr;
  logic      sel_sram;
  logic      sel_flash;
  logic      sel_crtc;
  logic      sel_gpio;
  logic      sel_none;
  logic      err_q;

  assign addr = req.paddr;

  always_comb
  begin
    sel_sram  = 1'b0;
    sel_flash = 1'b0;
    sel_crtc  = 1'b0;
    sel_gpio  = 1'b0;
    sel_none  = 1'b0;
    case (addr.mem.region)
      sram_lo, sram_hi: sel_sram = 1'b1;
      flash:            sel_flash = 1'b1;
      default:
      begin
        // io region decodes the block field
        case (addr.io.block)
          crtc:    sel_crtc = 1'b1;
          gpio:    sel_gpio = 1'b1;
          default: sel_none = 1'b1;
        endcase
      end
    endcase
  end

  always_comb
  begin
    sram_req       = req;
    flash_req      = req;
    crtc_req       = req;
    gpio_req       = req;
    sram_req.psel  = req.psel & sel_sram;
    flash_req.psel = req.psel & sel_flash;
    crtc_req.psel  = req.psel & sel_crtc;
    gpio_req.psel  = req.psel & sel_gpio;
  end

  // armed by the setup cycle, so the error lands in the access phase
  always_ff @(posedge clk_50)
  begin
    if (reset)
      err_q <= 1'b0;
    else
      err_q <= req.psel & ~req.penable & sel_none;
  end

  always_comb
  begin
    rsp = '0;
    if (sel_sram)
      rsp = sram_rsp;
    else if (sel_flash)
      rsp = flash_rsp;
    else if (sel_crtc)
      rsp = crtc_rsp;
    else if (sel_gpio)
      rsp = gpio_rsp;
    else
    begin
      rsp.pready  = err_q & req.penable;
      rsp.pslverr = err_q & req.penable;
    end
  end

endmodule

//--- logic/board_pins_pkg.sv
// Board side pin groups for the external memories.
// The SRAM and flash bridges drive these toward the devices; data buses
// are kept outside the structs since they run in the other direction.
package board_pins_pkg;

  typedef struct packed {
    logic [17:0] addr;
    logic        we_n;
    logic        oe_n;
    logic        ce_n;
    logic [1:0]  bw_n;
  } sram_pins_t;

  typedef struct packed {
    logic [17:0] addr;
    logic        we_n;
    logic        oe_n;
    logic        rst_n;
  } flash_pins_t;

endpackage

//--- logic/bus_defs_pkg.sv
// Shared APB bus types for the board model.
// Holds the request and response structs, the address map regions and
// the two views of the APB address used by the decoder and the targets.
package bus_defs_pkg;

  typedef enum logic [1:0] {
    sram_lo = 2'd0,
    sram_hi = 2'd1,
    flash   = 2'd2,
    io      = 2'd3
  } region_e;

  typedef enum logic [1:0] {
    crtc        = 2'd0,
    gpio        = 2'd1,
    blk_spare_2 = 2'd2,
    blk_spare_3 = 2'd3
  } io_block_e;

  typedef struct packed {
    logic [19:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] pwdata;
    logic [1:0]  pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // memory targets see a flat byte offset
  typedef struct packed {
    region_e     region;
    logic [17:0] offset;
  } mem_view_t;

  // io targets see a block select and a word register index
  typedef struct packed {
    region_e     region;
    logic [9:0]  spare;
    io_block_e   block;
    logic [3:0]  reg_idx;
    logic [1:0]  byte_sel;
  } io_view_t;

  typedef union packed {
    mem_view_t mem;
    io_view_t  io;
  } apb_addr_u;

endpackage

//--- logic/crtc_regs.sv
// CRTC register file behind an index/data pair.
// Register 0 holds the 5-bit index, register 1 reads and writes the
// 8-bit CRTC register that the index points at.
`timescale 1ns/100ps

module crtc_regs
  import bus_defs_pkg::*;
#(
  parameter int crtc_count = 25
)
(
  input  logic     clk_50,
  input  logic     reset,
  input  apb_req_t req,
  output apb_rsp_t rsp
);

  apb_addr_u  addr;
  logic [4:0] index_q;
  logic [7:0] data_q [crtc_count];
  logic       access;
  logic       wr_en;
  logic       idx_valid;

  assign addr      = req.paddr;
  assign access    = req.psel & req.penable;
  assign wr_en     = access & req.pwrite;
  assign idx_valid = (int'(index_q) < crtc_count);

  always_ff @(posedge clk_50)
  begin
    if (reset)
    begin
      index_q <= '0;
      for (int i = 0; i < crtc_count; i++)
        data_q[i] <= '0;
    end
    else if (wr_en)
    begin
      case (addr.io.reg_idx)
        4'd0: index_q <= req.pwdata[4:0];
        // out of range index drops the write
        4'd1: if (idx_valid) data_q[index_q] <= req.pwdata[7:0];
        default: ;
      endcase
    end
  end

  always_comb
  begin
    rsp.prdata  = '0;
    rsp.pready  = access;
    rsp.pslverr = 1'b0;
    case (addr.io.reg_idx)
      4'd0: rsp.prdata = {11'b0, index_q};
      4'd1: if (idx_valid) rsp.prdata = {8'b0, data_q[index_q]};
      default: ;
    endcase
  end

endmodule

//--- logic/flash_bridge.sv
// APB read port for the 8-bit flash.
// A 16-bit word read is done as two byte reads of flash_wait cycles each,
// low byte at the even address first. The word is returned one cycle
// after the high byte read. Flash writes are answered with an error.
`timescale 1ns/100ps

module flash_bridge
  import bus_defs_pkg::*;
  import board_pins_pkg::*;
#(
  parameter int flash_wait = 3
)
(
  input  logic        clk_50,
  input  logic        reset,
  input  apb_req_t    req,
  output apb_rsp_t    rsp,
  output flash_pins_t pins,
  input  logic [7:0]  flash_dq
);

  localparam int cnt_w = (flash_wait > 1) ? $clog2(flash_wait) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_low,
    st_high,
    st_done
  } state_t;

  state_t           state;
  logic [cnt_w-1:0] wait_cnt;
  logic [7:0]       low_q;
  logic             rd_start;
  logic             byte_end;

  // start on the setup cycle so the first byte fills access cycle one
  assign rd_start = req.psel & ~req.penable & ~req.pwrite;
  assign byte_end = (wait_cnt == cnt_w'(flash_wait - 1));

  always_ff @(posedge clk_50)
  begin
    if (reset)
    begin
      state    <= st_idle;
      wait_cnt <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          wait_cnt <= '0;
          if (rd_start)
            state <= st_low;
        end
        st_low, st_high:
        begin
          if (byte_end)
          begin
            wait_cnt <= '0;
            state    <= (state == st_low) ? st_high : st_done;
          end
          else
            wait_cnt <= wait_cnt + cnt_w'(1);
        end
        default: state <= st_idle;
      endcase
    end
  end

  // low byte held while the odd address is read
  always_ff @(posedge clk_50)
  begin
    if (state == st_low && byte_end)
      low_q <= flash_dq;
  end

  always_comb
  begin
    pins.addr  = {req.paddr[17:1], (state == st_high) || (state == st_done)};
    pins.oe_n  = (state == st_idle);
    pins.we_n  = 1'b1;
    pins.rst_n = ~reset;
  end

  always_comb
  begin
    rsp = '0;
    if (state == st_done)
    begin
      rsp.prdata = {flash_dq, low_q};
      rsp.pready = 1'b1;
    end
    else if (state == st_idle && req.psel && req.penable && req.pwrite)
    begin
      rsp.pready  = 1'b1;
      rsp.pslverr = 1'b1;
    end
  end

endmodule

//--- logic/gpio_port.sv
// Switch and LED port.
// Reg 0 is the red LEDs, reg 1 the green LEDs, reg 2 the synchronized
// switches; any other register answers with an error.
`timescale 1ns/100ps

module gpio_port
  import bus_defs_pkg::*;
(
  input  logic       clk_50,
  input  logic       reset,
  input  apb_req_t   req,
  output apb_rsp_t   rsp,
  input  logic [9:0] sw,
  output logic [9:0] ledr,
  output logic [7:0] ledg
);

  apb_addr_u  addr;
  logic [9:0] sw_meta;
  logic [9:0] sw_sync;
  logic [9:0] ledr_q;
  logic [7:0] ledg_q;
  logic       access;
  logic       bad_reg;

  assign addr    = req.paddr;
  assign access  = req.psel & req.penable;
  assign bad_reg = (addr.io.reg_idx > 4'd2);

  // two flops since the switches are asynchronous to clk_50
  always_ff @(posedge clk_50)
  begin
    sw_meta <= sw;
    sw_sync <= sw_meta;
  end

  always_ff @(posedge clk_50)
  begin
    if (reset)
    begin
      ledr_q <= '0;
      ledg_q <= '0;
    end
    else if (access && req.pwrite)
    begin
      case (addr.io.reg_idx)
        4'd0: ledr_q <= req.pwdata[9:0];
        4'd1: ledg_q <= req.pwdata[7:0];
        default: ;
      endcase
    end
  end

  assign ledr = ledr_q;
  assign ledg = ledg_q;

  always_comb
  begin
    rsp.prdata  = '0;
    rsp.pready  = access;
    rsp.pslverr = access & bad_reg;
    case (addr.io.reg_idx)
      4'd0: rsp.prdata = {6'b0, ledr_q};
      4'd1: rsp.prdata = {8'b0, ledg_q};
      4'd2: rsp.prdata = {6'b0, sw_sync};
      default: ;
    endcase
  end

endmodule

//--- logic/soc_top.sv
// Top of the memory and configuration side of the board.
// The APB master connects here; the decoder splits traffic between
// SRAM, flash, the CRTC registers and the switch/LED port.
`timescale 1ns/100ps

module soc_top
  import bus_defs_pkg::*;
  import board_pins_pkg::*;
#(
  parameter int sram_wait  = 2,
  parameter int flash_wait = 3,
  parameter int crtc_count = 25
)
(
  input  logic        clk_50,
  input  logic        reset,
  input  apb_req_t    req,
  output apb_rsp_t    rsp,
  output sram_pins_t  sram_pins,
  output logic [15:0] sram_dq_out,
  output logic        sram_dq_oe,
  input  logic [15:0] sram_dq_in,
  output flash_pins_t flash_pins,
  input  logic [7:0]  flash_dq,
  input  logic [9:0]  sw,
  output logic [9:0]  ledr,
  output logic [7:0]  ledg
);

  apb_req_t sram_req;
  apb_req_t flash_req;
  apb_req_t crtc_req;
  apb_req_t gpio_req;
  apb_rsp_t sram_rsp;
  apb_rsp_t flash_rsp;
  apb_rsp_t crtc_rsp;
  apb_rsp_t gpio_rsp;

  apb_decoder u_decoder (
    .clk_50    (clk_50),
    .reset     (reset),
    .req       (req),
    .rsp       (rsp),
    .sram_req  (sram_req),
    .flash_req (flash_req),
    .crtc_req  (crtc_req),
    .gpio_req  (gpio_req),
    .sram_rsp  (sram_rsp),
    .flash_rsp (flash_rsp),
    .crtc_rsp  (crtc_rsp),
    .gpio_rsp  (gpio_rsp)
  );

  sram_bridge #(
    .sram_wait (sram_wait)
  ) u_sram (
    .clk_50      (clk_50),
    .reset       (reset),
    .req         (sram_req),
    .rsp         (sram_rsp),
    .pins        (sram_pins),
    .sram_dq_out (sram_dq_out),
    .sram_dq_oe  (sram_dq_oe),
    .sram_dq_in  (sram_dq_in)
  );

  flash_bridge #(
    .flash_wait (flash_wait)
  ) u_flash (
    .clk_50   (clk_50),
    .reset    (reset),
    .req      (flash_req),
    .rsp      (flash_rsp),
    .pins     (flash_pins),
    .flash_dq (flash_dq)
  );

  crtc_regs #(
    .crtc_count (crtc_count)
  ) u_crtc (
    .clk_50 (clk_50),
    .reset  (reset),
    .req    (crtc_req),
    .rsp    (crtc_rsp)
  );

  gpio_port u_gpio (
    .clk_50 (clk_50),
    .reset  (reset),
    .req    (gpio_req),
    .rsp    (gpio_rsp),
    .sw     (sw),
    .ledr   (ledr),
    .ledg   (ledg)
  );

endmodule

//--- logic/sram_bridge.sv
// APB target for the asynchronous 16-bit SRAM.
// Each transfer holds chip enable for sram_wait access cycles. Writes
// pulse we_n and drive data up to the cycle before pready; reads keep
// oe_n low and hand the pin data back in the pready cycle.
`timescale 1ns/100ps

module sram_bridge
  import bus_defs_pkg::*;
  import board_pins_pkg::*;
#(
  parameter int sram_wait = 2
)
(
  input  logic        clk_50,
  input  logic        reset,
  input  apb_req_t    req,
  output apb_rsp_t    rsp,
  output sram_pins_t  pins,
  output logic [15:0] sram_dq_out,
  output logic        sram_dq_oe,
  input  logic [15:0] sram_dq_in
);

  localparam int cnt_w = (sram_wait > 1) ? $clog2(sram_wait) : 1;

  logic [cnt_w-1:0] wait_cnt;
  logic             access;
  logic             last;
  logic             wr_drive;

  assign access   = req.psel & req.penable;
  assign last     = access & (wait_cnt == cnt_w'(sram_wait - 1));
  assign wr_drive = access & req.pwrite & ~last;

  // counts access cycles and clears on the pready cycle
  always_ff @(posedge clk_50)
  begin
    if (reset)
      wait_cnt <= '0;
    else if (last)
      wait_cnt <= '0;
    else if (access)
      wait_cnt <= wait_cnt + cnt_w'(1);
  end

  always_comb
  begin
    // word address drops byte bit 0
    pins.addr = req.paddr[18:1];
    pins.ce_n = ~access;
    pins.oe_n = ~(access & ~req.pwrite);
    pins.we_n = ~wr_drive;
    // reads enable both lanes
    pins.bw_n = req.pwrite ? ~req.pstrb : 2'b00;
  end

  assign sram_dq_out = req.pwdata;
  assign sram_dq_oe  = wr_drive;

  always_comb
  begin
    rsp.prdata  = sram_dq_in;
    rsp.pready  = last;
    rsp.pslverr = 1'b0;
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the soc testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_soc -o tb_soc > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0

//--- sim.f
logic/bus_defs_pkg.sv
logic/board_pins_pkg.sv
logic/apb_decoder.sv
logic/sram_bridge.sv
logic/flash_bridge.sv
logic/crtc_regs.sv
logic/gpio_port.sv
logic/soc_top.sv
verif/tb_clock.sv
verif/tb_mem_models.sv
verif/tb_soc.sv

//--- verif/tb_clock.sv
// Clock and reset source for the board testbench.
// Makes clk_50 with a 100 ns period and holds reset high for the first
// reset_cycles rising edges, releasing it just after an edge.
`timescale 1ns/100ps

module tb_clock #(
  parameter int reset_cycles = 8
)
(
  output logic clk_50,
  output logic reset
);

  initial
  begin
    clk_50 = 1'b0;
    forever #50 clk_50 = ~clk_50;
  end

  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk_50);
    #1 reset = 1'b0;
  end

endmodule

//--- verif/tb_mem_models.sv
// Behavioral board memories for the testbench.
// sram_model is an asynchronous 16-bit SRAM with byte lanes, written on
// the rising edge of we_n. flash_model is an 8-bit read-only flash whose
// contents come from $random at time zero.
`timescale 1ns/100ps

module sram_model
  import board_pins_pkg::*;
(
  input  sram_pins_t  pins,
  input  logic [15:0] dq_out,
  input  logic        dq_oe,
  output logic [15:0] dq_in
);

  logic [15:0] mem [0:262143];
  logic        we_n;

  assign we_n  = pins.we_n;
  // the device only drives while the bridge has released the bus
  assign dq_in = (!pins.ce_n && !pins.oe_n && !dq_oe) ? mem[pins.addr] : 16'h0000;

  initial
  begin
    for (int a = 0; a < 262144; a++)
      mem[a] = 16'h0000;
  end

  // end of the write pulse latches the enabled lanes
  always @(posedge we_n)
  begin
    if (!pins.ce_n)
    begin
      if (!pins.bw_n[0])
        mem[pins.addr][7:0] = dq_out[7:0];
      if (!pins.bw_n[1])
        mem[pins.addr][15:8] = dq_out[15:8];
    end
  end

endmodule

module flash_model
  import board_pins_pkg::*;
(
  input  flash_pins_t pins,
  output logic [7:0]  dq
);

  logic [7:0] mem [0:262143];
  integer     fill_seed;

  initial
  begin
    fill_seed = 32'h266f;
    for (int a = 0; a < 262144; a++)
      mem[a] = 8'($random(fill_seed));
  end

  assign dq = (pins.rst_n && !pins.oe_n) ? mem[pins.addr] : 8'h00;

endmodule

//--- verif/tb_soc.sv
// Testbench for soc_top.
// Plays the APB master with random transfers to SRAM, flash, the CRTC
// registers and the switch/LED port, and checks every response against
// shadow copies kept here. Prints an error count and the final status.
`timescale 1ns/100ps

module tb_soc;
  import bus_defs_pkg::*;
  import board_pins_pkg::*;

  localparam int sram_wait    = 2;
  localparam int flash_wait   = 3;
  localparam int crtc_count   = 25;
  localparam int xfer_budget  = 350;
  localparam int n_sram       = 24;

  logic        clk_50;
  logic        reset;
  apb_req_t    req;
  apb_rsp_t    rsp;
  sram_pins_t  sram_pins;
  logic [15:0] sram_dq_out;
  logic        sram_dq_oe;
  logic [15:0] sram_dq_in;
  flash_pins_t flash_pins;
  logic [7:0]  flash_dq;
  logic [9:0]  sw;
  logic [9:0]  ledr;
  logic [7:0]  ledg;

  integer      seed;
  int          errors;
  logic [15:0] sram_shadow [logic [17:0]];
  logic [7:0]  flash_ref [0:262143];
  logic [7:0]  crtc_shadow [0:31];
  logic [9:0]  ledr_sh;
  logic [7:0]  ledg_sh;
  logic [17:0] sram_addrs [n_sram];

  tb_clock #(.reset_cycles(8)) u_clock (.clk_50(clk_50), .reset(reset));

  soc_top #(
    .sram_wait  (sram_wait),
    .flash_wait (flash_wait),
    .crtc_count (crtc_count)
  ) u_dut (
    .clk_50      (clk_50),
    .reset       (reset),
    .req         (req),
    .rsp         (rsp),
    .sram_pins   (sram_pins),
    .sram_dq_out (sram_dq_out),
    .sram_dq_oe  (sram_dq_oe),
    .sram_dq_in  (sram_dq_in),
    .flash_pins  (flash_pins),
    .flash_dq    (flash_dq),
    .sw          (sw),
    .ledr        (ledr),
    .ledg        (ledg)
  );

  sram_model u_sram_mdl (
    .pins(sram_pins), .dq_out(sram_dq_out), .dq_oe(sram_dq_oe), .dq_in(sram_dq_in)
  );

  flash_model u_flash_mdl (.pins(flash_pins), .dq(flash_dq));

  task automatic check_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp,
                           input bit cmp_data);
    if (got.pready !== exp.pready || got.pslverr !== exp.pslverr ||
        (cmp_data && got.prdata !== exp.prdata))
    begin
      $display("mismatch %s rsp: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_sram_pins(input string name, input sram_pins_t exp);
    if (sram_pins !== exp)
    begin
      $display("mismatch %s sram_pins: got %h expected %h", name, sram_pins, exp);
      errors++;
    end
  endtask

  task automatic check_flash_pins(input string name, input flash_pins_t exp);
    if (flash_pins !== exp)
    begin
      $display("mismatch %s flash_pins: got %h expected %h", name, flash_pins, exp);
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [19:0] io_addr(input logic [1:0] blk, input logic [3:0] rg);
    return {2'b11, 10'b0, blk, rg, 2'b00};
  endfunction

  function automatic apb_rsp_t ok_rsp(input logic [15:0] data);
    apb_rsp_t r;
    r.prdata  = data;
    r.pready  = 1'b1;
    r.pslverr = 1'b0;
    return r;
  endfunction

  // drives one APB transfer and waits for pready
  task automatic apb_xfer(input logic [19:0] addr, input logic wr, input logic [15:0] wdata,
                          input logic [1:0] strb, input bit pin_chk, output apb_rsp_t got);
    sram_pins_t exp_pins;
    @(posedge clk_50);
    #1;
    req.paddr   = addr;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = wr;
    req.pwdata  = wdata;
    req.pstrb   = strb;
    @(posedge clk_50);
    #1;
    req.penable = 1'b1;
    @(negedge clk_50);
    if (pin_chk)
    begin
      exp_pins = '{addr: addr[18:1], we_n: 1'b0, oe_n: 1'b1, ce_n: 1'b0, bw_n: ~strb};
      check_sram_pins("sram write", exp_pins);
      check_value("sram_dq_oe", {15'h0, sram_dq_oe}, 16'h1);
    end
    while (!rsp.pready)
      @(negedge clk_50);
    got = rsp;
    @(posedge clk_50);
    #1;
    req.psel    = 1'b0;
    req.penable = 1'b0;
  endtask

  task automatic sram_read_check(input logic [17:0] waddr);
    apb_rsp_t    got;
    logic [15:0] exp;
    exp = sram_shadow.exists(waddr) ? sram_shadow[waddr] : 16'h0000;
    apb_xfer({1'b0, waddr, 1'b0}, 1'b0, 16'h0, 2'b11, 1'b0, got);
    check_rsp("sram read", got, ok_rsp(exp), 1'b1);
  endtask

  task automatic crtc_table_check();
    apb_rsp_t got;
    for (int i = 0; i < 32; i++)
    begin
      apb_xfer(io_addr(2'd0, 4'd0), 1'b1, 16'(i), 2'b11, 1'b0, got);
      apb_xfer(io_addr(2'd0, 4'd1), 1'b0, 16'h0, 2'b11, 1'b0, got);
      check_rsp("crtc read", got, ok_rsp((i < crtc_count) ? {8'h00, crtc_shadow[i]} : 16'h0),
                1'b1);
    end
  endtask

  initial
  begin
    apb_rsp_t    got;
    apb_rsp_t    err_rsp;
    logic [31:0] r;
    logic [17:0] off;
    logic [15:0] wd;
    logic [4:0]  idx;

    seed    = 32'h266f;
    errors  = 0;
    req     = '0;
    sw      = 10'h000;
    ledr_sh = '0;
    ledg_sh = '0;
    err_rsp = '{prdata: 16'h0, pready: 1'b1, pslverr: 1'b1};
    for (int i = 0; i < 32; i++)
      crtc_shadow[i] = 8'h00;

    // flash held in reset while reset is high
    @(negedge clk_50);
    @(negedge clk_50);
    check_flash_pins("in reset", '{addr: 18'h0, we_n: 1'b1, oe_n: 1'b1, rst_n: 1'b0});
    wait (!reset);
    @(negedge clk_50);
    check_sram_pins("after reset", '{addr: 18'h0, we_n: 1'b1, oe_n: 1'b1, ce_n: 1'b1,
                                     bw_n: 2'b00});
    check_flash_pins("after reset", '{addr: 18'h0, we_n: 1'b1, oe_n: 1'b1, rst_n: 1'b1});
    check_value("sram_dq_oe", {15'h0, sram_dq_oe}, 16'h0);
    check_value("ledr", {6'h0, ledr}, 16'h0);
    check_value("ledg", {8'h0, ledg}, 16'h0);
    for (int a = 0; a < 262144; a++)
      flash_ref[a] = u_flash_mdl.mem[a];

    // SRAM writes with random strobes and their readback
    for (int i = 0; i < n_sram; i++)
    begin
      r = $random(seed);
      off = r[17:0] & 18'h2003f;
      sram_addrs[i] = off;
      r = $random(seed);
      apb_xfer({1'b0, off, 1'b0}, 1'b1, r[15:0], r[17:16], 1'b1, got);
      check_rsp("sram write", got, ok_rsp(16'h0), 1'b0);
      wd = sram_shadow.exists(off) ? sram_shadow[off] : 16'h0000;
      if (r[16])
        wd[7:0] = r[7:0];
      if (r[17])
        wd[15:8] = r[15:8];
      sram_shadow[off] = wd;
    end
    for (int i = 0; i < n_sram; i++)
      sram_read_check(sram_addrs[i]);

    // little-endian flash word reads and rejected writes
    for (int i = 0; i < 20; i++)
    begin
      r = $random(seed);
      off = r[17:0] & 18'h3fffe;
      if (i % 5 == 4)
      begin
        apb_xfer({2'b10, off}, 1'b1, r[31:16], 2'b11, 1'b0, got);
        check_rsp("flash write", got, err_rsp, 1'b1);
      end
      else
      begin
        apb_xfer({2'b10, off}, 1'b0, 16'h0, 2'b11, 1'b0, got);
        check_rsp("flash read", got, ok_rsp({flash_ref[off | 18'h1], flash_ref[off]}), 1'b1);
      end
    end

    // CRTC index/data writes
    for (int i = 0; i < 20; i++)
    begin
      r = $random(seed);
      idx = r[4:0];
      apb_xfer(io_addr(2'd0, 4'd0), 1'b1, {11'h0, idx}, 2'b11, 1'b0, got);
      check_rsp("crtc index write", got, ok_rsp(16'h0), 1'b0);
      apb_xfer(io_addr(2'd0, 4'd0), 1'b0, 16'h0, 2'b11, 1'b0, got);
      check_rsp("crtc index read", got, ok_rsp({11'h0, idx}), 1'b1);
      apb_xfer(io_addr(2'd0, 4'd1), 1'b1, {8'h00, r[15:8]}, 2'b11, 1'b0, got);
      check_rsp("crtc data write", got, ok_rsp(16'h0), 1'b0);
      if (int'(idx) < crtc_count)
        crtc_shadow[idx] = r[15:8];
    end
    crtc_table_check();

    // LEDs and synchronized switches
    for (int i = 0; i < 8; i++)
    begin
      r = $random(seed);
      ledr_sh = r[9:0];
      ledg_sh = r[17:10];
      apb_xfer(io_addr(2'd1, 4'd0), 1'b1, {6'h0, ledr_sh}, 2'b11, 1'b0, got);
      apb_xfer(io_addr(2'd1, 4'd1), 1'b1, {8'h0, ledg_sh}, 2'b11, 1'b0, got);
      check_value("ledr", {6'h0, ledr}, {6'h0, ledr_sh});
      check_value("ledg", {8'h0, ledg}, {8'h0, ledg_sh});
      apb_xfer(io_addr(2'd1, 4'd0), 1'b0, 16'h0, 2'b11, 1'b0, got);
      check_rsp("ledr read", got, ok_rsp({6'h0, ledr_sh}), 1'b1);
      apb_xfer(io_addr(2'd1, 4'd1), 1'b0, 16'h0, 2'b11, 1'b0, got);
      check_rsp("ledg read", got, ok_rsp({8'h0, ledg_sh}), 1'b1);
      @(posedge clk_50);
      #1 sw = r[27:18];
      repeat (3) @(posedge clk_50);
      apb_xfer(io_addr(2'd1, 4'd2), 1'b0, 16'h0, 2'b11, 1'b0, got);
      check_rsp("sw read", got, ok_rsp({6'h0, r[27:18]}), 1'b1);
    end
    apb_xfer(io_addr(2'd1, 4'd3), 1'b0, 16'h0, 2'b11, 1'b0, got);
    check_rsp("gpio reg 3", got, err_rsp, 1'b1);

    // unused io blocks answer with an error and touch nothing
    for (int i = 0; i < 8; i++)
    begin
      r = $random(seed);
      apb_xfer(io_addr({1'b1, r[0]}, r[5:2]), r[1], r[31:16], 2'b11, 1'b0, got);
      check_rsp("unused block", got, err_rsp, 1'b1);
    end
    check_value("ledr", {6'h0, ledr}, {6'h0, ledr_sh});
    check_value("ledg", {8'h0, ledg}, {8'h0, ledg_sh});
    crtc_table_check();
    for (int i = 0; i < n_sram; i++)
      sram_read_check(sram_addrs[i]);

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // watchdog sized from the transfer count and the slowest transfer
  initial
  begin
    #(xfer_budget * (2 * flash_wait + 4) * 100 + 800);
    $display("timeout: the run did not finish in time, a transfer never got pready");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
